//--- source/umi_remap_params.svh
//****************************************
// shared sizing for the umi remap stage
// widths, chip-id field position, table size
// and the credit counts of both ports
// include wherever a module needs them
//****************************************

`ifndef UMI_REMAP_PARAMS_SVH
`define UMI_REMAP_PARAMS_SVH

// umi field widths
`define UMI_CW          32      // command
`define UMI_AW          64      // address
`define UMI_DW          64      // data

// chip-id field inside the address, bits 55:40
`define UMI_IDW         16
`define UMI_IDSB        40

// remap table entries
`define UMI_NMAPS       8

// ingress buffer depth, also the sender's starting credits
`define UMI_FIFO_DEPTH  4

// credits held toward the fabric after reset
`define UMI_OUT_CREDITS 3

// config register index width
`define UMI_CFG_AW      5

`endif

//--- source/umi_remap_pkg.sv
//****************************************
// types shared by the remap stage
// import with umi_remap_pkg::* in the
// module header
//****************************************

`include "umi_remap_params.svh"

package umi_remap_pkg;

    // umi beat fields
    typedef logic [`UMI_CW-1:0]     umi_cmd_t;
    typedef logic [`UMI_AW-1:0]     umi_addr_t;  // also the cfg write data
    typedef logic [`UMI_DW-1:0]     umi_data_t;

    // chip-id field of an address
    typedef logic [`UMI_IDW-1:0]    umi_chipid_t;

    // config register index
    typedef logic [`UMI_CFG_AW-1:0] cfg_addr_t;

    // output control fsm
    typedef enum logic [1:0] {
        ST_IDLE        = 2'd0,  // nothing buffered
        ST_SEND        = 2'd1,  // beat on the output this cycle
        ST_WAIT_CREDIT = 2'd2   // data waiting, no downstream credit
    } ctrl_state_t;

endpackage

//--- source/umi_credit_fifo.sv
//****************************************
// ingress buffer for umi requests
// sender spends a credit per push, every
// pop hands one back on credit next cycle
//****************************************

`timescale 1ns/100ps

`include "umi_remap_params.svh"

module umi_credit_fifo
    import umi_remap_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  logic      push,
    input  umi_cmd_t  push_cmd,
    input  umi_addr_t push_dstaddr,
    input  umi_addr_t push_srcaddr,
    input  umi_data_t push_data,
    input  logic      pop,
    output umi_cmd_t  head_cmd,
    output umi_addr_t head_dstaddr,
    output umi_addr_t head_srcaddr,
    output umi_data_t head_data,
    output logic      empty,
    output logic      credit
);

    localparam int DEPTH = `UMI_FIFO_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    // storage, one array per field
    umi_cmd_t   mem_cmd     [DEPTH];
    umi_addr_t  mem_dstaddr [DEPTH];
    umi_addr_t  mem_srcaddr [DEPTH];
    umi_data_t  mem_data    [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    // write side, no reset on payload
    always_ff @(posedge clk) begin
        if (push) begin
            mem_cmd[wr_ptr]     <= push_cmd;
            mem_dstaddr[wr_ptr] <= push_dstaddr;
            mem_srcaddr[wr_ptr] <= push_srcaddr;
            mem_data[wr_ptr]    <= push_data;
        end
    end

    // pointers, occupancy and the returned credit
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            credit <= 1'b0;
        end else begin
            if (push)
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;  // both or neither, count holds
            endcase
            credit <= pop;  // one pulse per freed slot
        end
    end

    assign empty = (count == '0);

    // head is read straight from the array
    assign head_cmd     = mem_cmd[rd_ptr];
    assign head_dstaddr = mem_dstaddr[rd_ptr];
    assign head_srcaddr = mem_srcaddr[rd_ptr];
    assign head_data    = mem_data[rd_ptr];

endmodule

//--- source/umi_addr_remap.sv
//****************************************
// destination address remap, combinational
// local chipid first, then the offset
// window, then the id table, else as is
//****************************************

`timescale 1ns/100ps

`include "umi_remap_params.svh"

module umi_addr_remap
    import umi_remap_pkg::*;
#(
    parameter int NMAPS = `UMI_NMAPS
) (
    input  umi_addr_t                 in_dstaddr,
    input  umi_chipid_t               chipid,
    input  umi_addr_t                 win_low,
    input  umi_addr_t                 win_high,
    input  umi_addr_t                 win_offset,
    input  logic [NMAPS*`UMI_IDW-1:0] map_old,
    input  logic [NMAPS*`UMI_IDW-1:0] map_new,
    input  logic [NMAPS-1:0]          map_valid,
    output umi_addr_t                 out_dstaddr
);

    localparam int IDW  = `UMI_IDW;
    localparam int IDSB = `UMI_IDSB;
    localparam int AW   = `UMI_AW;

    umi_chipid_t id_field;
    umi_chipid_t new_id;
    umi_addr_t   addr_mapped;
    logic        is_local;
    logic        in_window;

    assign id_field = in_dstaddr[IDSB+IDW-1:IDSB];

    // priority chain, built from the top entry down
    // so entry 0 has the final say
    umi_chipid_t chain [NMAPS+1];
    assign chain[NMAPS] = id_field;  // no hit, keep the id

    genvar i;
    generate
        for (i = NMAPS - 1; i >= 0; i--) begin : g_match
            logic hit;
            assign hit      = map_valid[i] && (map_old[i*IDW +: IDW] == id_field);
            assign chain[i] = hit ? map_new[i*IDW +: IDW] : chain[i+1];
        end
    endgenerate

    assign new_id = chain[0];

    // splice the new id back into the address
    generate
        if ((IDSB + IDW) < AW) begin : g_with_msb
            assign addr_mapped = {in_dstaddr[AW-1:IDSB+IDW], new_id, in_dstaddr[IDSB-1:0]};
        end else begin : g_no_msb
            assign addr_mapped = {new_id, in_dstaddr[IDSB-1:0]};  // id at the top
        end
    endgenerate

    assign is_local  = (id_field == chipid);
    assign in_window = (in_dstaddr >= win_low) && (in_dstaddr <= win_high);  // inclusive

    always_comb begin
        if (is_local)
            out_dstaddr = in_dstaddr;               // our own chip
        else if (in_window)
            out_dstaddr = in_dstaddr - win_offset;  // window relocation
        else
            out_dstaddr = addr_mapped;              // table hit or unchanged id
    end

endmodule

//--- source/umi_remap_cfg.sv
//****************************************
// config registers for the remap stage
// chipid, window low/high/offset and the
// id table, loaded by single-cycle writes
//****************************************

`timescale 1ns/100ps

`include "umi_remap_params.svh"

module umi_remap_cfg
    import umi_remap_pkg::*;
#(
    parameter int NMAPS = `UMI_NMAPS
) (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      cfg_write,
    input  cfg_addr_t                 cfg_addr,
    input  umi_addr_t                 cfg_wdata,
    output umi_chipid_t               chipid,
    output umi_addr_t                 win_low,
    output umi_addr_t                 win_high,
    output umi_addr_t                 win_offset,
    output logic [NMAPS*`UMI_IDW-1:0] map_old,
    output logic [NMAPS*`UMI_IDW-1:0] map_new,
    output logic [NMAPS-1:0]          map_valid
);

    // register map
    localparam cfg_addr_t REG_CHIPID = cfg_addr_t'(0);
    localparam cfg_addr_t REG_LOW    = cfg_addr_t'(1);
    localparam cfg_addr_t REG_HIGH   = cfg_addr_t'(2);
    localparam cfg_addr_t REG_OFFSET = cfg_addr_t'(3);
    localparam int        MAP_BASE   = 16;  // first table slot

    // scalar registers
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            chipid     <= '0;
            win_low    <= '1;   // low above high, window empty
            win_high   <= '0;
            win_offset <= '0;
        end else if (cfg_write) begin
            case (cfg_addr)
                REG_CHIPID: chipid     <= cfg_wdata[`UMI_IDW-1:0];
                REG_LOW:    win_low    <= cfg_wdata;
                REG_HIGH:   win_high   <= cfg_wdata;
                REG_OFFSET: win_offset <= cfg_wdata;
                default:    ;  // table or unused index
            endcase
        end
    end

    // one slot per table entry
    genvar i;
    generate
        for (i = 0; i < NMAPS; i++) begin : g_map
            logic sel;
            assign sel = cfg_write && (cfg_addr == cfg_addr_t'(MAP_BASE + i));

            // valid flag is control state
            always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n)
                    map_valid[i] <= 1'b0;
                else if (sel)
                    map_valid[i] <= cfg_wdata[32];
            end

            // ids only matter once valid is set
            always_ff @(posedge clk) begin
                if (sel) begin
                    map_old[i*`UMI_IDW +: `UMI_IDW] <= cfg_wdata[15:0];   // old id
                    map_new[i*`UMI_IDW +: `UMI_IDW] <= cfg_wdata[31:16];  // new id
                end
            end
        end
    endgenerate

endmodule

//--- source/umi_remap_ctrl.sv
//****************************************
// output control for the remap stage
// pops the ingress buffer while downstream
// credit remains, registers the beat
//****************************************

`timescale 1ns/100ps

`include "umi_remap_params.svh"

module umi_remap_ctrl
    import umi_remap_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  logic      fifo_empty,
    input  umi_cmd_t  head_cmd,
    input  umi_addr_t head_srcaddr,
    input  umi_data_t head_data,
    input  umi_addr_t remap_dstaddr,
    input  logic      out_credit,
    output logic      fifo_pop,
    output logic      out_valid,
    output umi_cmd_t  out_cmd,
    output umi_addr_t out_dstaddr,
    output umi_addr_t out_srcaddr,
    output umi_data_t out_data
);

    localparam int CNT_W = $clog2(`UMI_OUT_CREDITS + 1);

    ctrl_state_t      state;
    ctrl_state_t      state_next;
    logic [CNT_W-1:0] credit_cnt;
    logic             has_credit;

    assign has_credit = (credit_cnt != '0);
    assign fifo_pop   = !fifo_empty && has_credit;  // issue whenever possible

    // downstream credits, spend and return may coincide
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            credit_cnt <= CNT_W'(`UMI_OUT_CREDITS);
        else begin
            case ({fifo_pop, out_credit})
                2'b10:   credit_cnt <= credit_cnt - 1'b1;
                2'b01:   credit_cnt <= credit_cnt + 1'b1;
                default: ;
            endcase
        end
    end

    // next state follows what happens at this edge
    always_comb begin
        if (fifo_pop)
            state_next = ST_SEND;
        else if (!fifo_empty)
            state_next = ST_WAIT_CREDIT;  // stalled on credit
        else
            state_next = ST_IDLE;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            state <= ST_IDLE;
        else
            state <= state_next;
    end

    // a beat is on the port only in ST_SEND
    assign out_valid = (state == ST_SEND);

    // output register, loaded with the pop
    always_ff @(posedge clk) begin
        if (fifo_pop) begin
            out_cmd     <= head_cmd;
            out_dstaddr <= remap_dstaddr;  // remapped head address
            out_srcaddr <= head_srcaddr;
            out_data    <= head_data;
        end
    end

endmodule

//--- source/umi_remap_top.sv
//****************************************
// umi request remap stage, top level
// credit port in, credit port out, plus a
// config write port for chipid/window/table
//****************************************

`timescale 1ns/100ps

`include "umi_remap_params.svh"

module umi_remap_top
    import umi_remap_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    // upstream
    input  logic        in_valid,
    input  umi_cmd_t    in_cmd,
    input  umi_addr_t   in_dstaddr,
    input  umi_addr_t   in_srcaddr,
    input  umi_data_t   in_data,
    output logic        in_credit,
    // toward the fabric
    output logic        out_valid,
    output umi_cmd_t    out_cmd,
    output umi_addr_t   out_dstaddr,
    output umi_addr_t   out_srcaddr,
    output umi_data_t   out_data,
    input  logic        out_credit,
    // config
    input  logic        cfg_write,
    input  cfg_addr_t   cfg_addr,
    input  umi_addr_t   cfg_wdata
);

    localparam int NMAPS = `UMI_NMAPS;

    logic                      fifo_empty;
    logic                      fifo_pop;
    umi_cmd_t                  head_cmd;
    umi_addr_t                 head_dstaddr;
    umi_addr_t                 head_srcaddr;
    umi_data_t                 head_data;
    umi_addr_t                 remap_dstaddr;
    umi_chipid_t               chipid;
    umi_addr_t                 win_low;
    umi_addr_t                 win_high;
    umi_addr_t                 win_offset;
    logic [NMAPS*`UMI_IDW-1:0] map_old;
    logic [NMAPS*`UMI_IDW-1:0] map_new;
    logic [NMAPS-1:0]          map_valid;

    umi_credit_fifo i_fifo (
        .clk          (clk),
        .arst_n       (arst_n),
        .push         (in_valid),
        .push_cmd     (in_cmd),
        .push_dstaddr (in_dstaddr),
        .push_srcaddr (in_srcaddr),
        .push_data    (in_data),
        .pop          (fifo_pop),
        .head_cmd     (head_cmd),
        .head_dstaddr (head_dstaddr),
        .head_srcaddr (head_srcaddr),
        .head_data    (head_data),
        .empty        (fifo_empty),
        .credit       (in_credit)
    );

    // remap works on the buffer head
    umi_addr_remap #(.NMAPS(NMAPS)) i_remap (
        .in_dstaddr  (head_dstaddr),
        .chipid      (chipid),
        .win_low     (win_low),
        .win_high    (win_high),
        .win_offset  (win_offset),
        .map_old     (map_old),
        .map_new     (map_new),
        .map_valid   (map_valid),
        .out_dstaddr (remap_dstaddr)
    );

    umi_remap_cfg #(.NMAPS(NMAPS)) i_cfg (
        .clk        (clk),
        .arst_n     (arst_n),
        .cfg_write  (cfg_write),
        .cfg_addr   (cfg_addr),
        .cfg_wdata  (cfg_wdata),
        .chipid     (chipid),
        .win_low    (win_low),
        .win_high   (win_high),
        .win_offset (win_offset),
        .map_old    (map_old),
        .map_new    (map_new),
        .map_valid  (map_valid)
    );

    umi_remap_ctrl i_ctrl (
        .clk           (clk),
        .arst_n        (arst_n),
        .fifo_empty    (fifo_empty),
        .head_cmd      (head_cmd),
        .head_srcaddr  (head_srcaddr),
        .head_data     (head_data),
        .remap_dstaddr (remap_dstaddr),
        .out_credit    (out_credit),
        .fifo_pop      (fifo_pop),
        .out_valid     (out_valid),
        .out_cmd       (out_cmd),
        .out_dstaddr   (out_dstaddr),
        .out_srcaddr   (out_srcaddr),
        .out_data      (out_data)
    );

endmodule

//--- verif/umi_remap_props.sv
//****************************************
// protocol checks for the remap stage
// bound into the control block and the
// ingress buffer, unused ports tied off
//****************************************

`timescale 1ns/100ps

`include "umi_remap_params.svh"

module umi_remap_props #(
    parameter int CRED_W = $clog2(`UMI_OUT_CREDITS + 1),
    parameter int OCC_W  = $clog2(`UMI_FIFO_DEPTH + 1)
) (
    input logic              clk,
    input logic              arst_n,
    input logic              out_valid,
    input logic              out_credit,   // credit returned by the fabric
    input logic              pop,          // beat issued at this edge
    input logic [CRED_W-1:0] credit_cnt,   // downstream credits held
    input logic              push,
    input logic [OCC_W-1:0]  occupancy     // ingress fill level
);

    // beats on the port not yet credited back, counted at the port only
    logic [CRED_W:0] in_flight;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            in_flight <= '0;
        else
            in_flight <= in_flight + out_valid - out_credit;
    end

    // a new beat needs an unreturned credit left
    a_valid_has_credit: assert property (
        @(posedge clk) disable iff (!arst_n) out_valid |-> (in_flight < `UMI_OUT_CREDITS)
    ) else $error("out_valid raised with no downstream credit");

    // a return at the full count only together with a spend
    a_credit_bounded: assert property (
        @(posedge clk) disable iff (!arst_n)
            (out_credit && !pop) |-> (credit_cnt < CRED_W'(`UMI_OUT_CREDITS))
    ) else $error("downstream credit counter above its limit");

    a_no_push_full: assert property (
        @(posedge clk) disable iff (!arst_n) push |-> (occupancy < OCC_W'(`UMI_FIFO_DEPTH))
    ) else $error("ingress buffer pushed while full");

endmodule

bind umi_remap_ctrl umi_remap_props i_props_ctrl (
    .clk        (clk),
    .arst_n     (arst_n),
    .out_valid  (out_valid),
    .out_credit (out_credit),
    .pop        (fifo_pop),
    .credit_cnt (credit_cnt),
    .push       (1'b0),
    .occupancy  ('0)
);

bind umi_credit_fifo umi_remap_props i_props_fifo (
    .clk        (clk),
    .arst_n     (arst_n),
    .out_valid  (1'b0),
    .out_credit (1'b0),
    .pop        (pop),
    .credit_cnt ('0),
    .push       (push),
    .occupancy  (count)
);

//--- verif/umi_remap_tb.sv
//****************************************
// testbench for the umi remap stage
// credit-limited sender, random credit
// return downstream, reference remap model
// and an in-order scoreboard on out_valid
//****************************************

`timescale 1ns/100ps

`include "umi_remap_params.svh"

module umi_remap_tb
    import umi_remap_pkg::*;
;

    localparam logic [31:0] SEED        = 32'd40982;
    localparam int          NMAPS       = `UMI_NMAPS;
    localparam int          DEPTH       = `UMI_FIFO_DEPTH;
    localparam int          OUT_CREDITS = `UMI_OUT_CREDITS;
    localparam int          N_DIRECTED  = 20;   // upper bound over both phases
    localparam int          N_RAND      = 40;   // per random phase
    localparam int          CYCLE_LIMIT = (N_DIRECTED + 2 * N_RAND) * 8 + 200;

    logic clk;
    logic arst_n;
    logic in_valid;
    umi_cmd_t in_cmd;
    umi_addr_t in_dstaddr;
    umi_addr_t in_srcaddr;
    umi_data_t in_data;
    logic in_credit;
    logic out_valid;
    umi_cmd_t out_cmd;
    umi_addr_t out_dstaddr;
    umi_addr_t out_srcaddr;
    umi_data_t out_data;
    logic out_credit;
    logic cfg_write;
    cfg_addr_t cfg_addr;
    umi_addr_t cfg_wdata;

    // testbench copy of the config registers
    umi_chipid_t chipid_m;
    umi_addr_t   low_m;
    umi_addr_t   high_m;
    umi_addr_t   offset_m;
    umi_chipid_t old_m   [NMAPS];
    umi_chipid_t new_m   [NMAPS];
    logic        valid_m [NMAPS];

    // scoreboard queues, one per field
    umi_cmd_t  exp_cmd_q [$];
    umi_addr_t exp_dst_q [$];
    umi_addr_t exp_src_q [$];
    umi_data_t exp_data_q[$];
    int        due_q     [$];   // cycles when a downstream credit goes back

    logic [31:0] stim_rng = SEED;
    logic [31:0] down_rng = SEED ^ 32'h5a5a_0f0f;  // own stream for the receiver
    int   down_max_delay  = 3;
    int   cyc             = 0;
    int   sent_cnt        = 0;
    int   up_returned     = 0;  // in_credit pulses seen
    int   beats_seen      = 0;
    int   down_returned   = 0;  // out_credit pulses given
    logic traffic_started = 1'b0;

    umi_remap_top i_umi_remap_top (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // halves swapped, the low lcg bits are weak
    function automatic logic [31:0] stim_rand();
        stim_rng = lcg_next(stim_rng);
        return {stim_rng[15:0], stim_rng[31:16]};
    endfunction

    function automatic umi_addr_t make_addr(input logic [7:0] top, input umi_chipid_t id,
                                            input logic [39:0] low);
        return {top, id, low};
    endfunction

    // expected address: local, window, first valid table hit, else as is
    function automatic umi_addr_t remap_addr(input umi_addr_t a);
        umi_chipid_t id;
        int          i;
        id = a[55:40];
        if (id == chipid_m)
            return a;
        if (a >= low_m && a <= high_m)
            return a - offset_m;
        for (i = 0; i < NMAPS; i++)
            if (valid_m[i] && old_m[i] == id)
                return {a[63:56], new_m[i], a[39:0]};
        return a;
    endfunction

    // mostly ids that hit a rule, some plain random
    function automatic umi_addr_t rand_addr();
        logic [31:0] r;
        logic [31:0] r2;
        umi_chipid_t id;
        r  = stim_rand();
        r2 = stim_rand();
        case (r[2:0])
            3'd0:    id = chipid_m;
            3'd1:    return low_m - 2 + (r2 % 32'h1004);      // around the low bound
            3'd2:    return high_m - 32'h1000 + (r2 % 32'h1004);  // around the high bound
            3'd3, 3'd4, 3'd5: id = old_m[int'(r[15:8]) % NMAPS];
            default: id = r[31:16];
        endcase
        return make_addr(r2[7:0], id, {r2[31:8], r[31:16]});
    endfunction

    task automatic abort_run();
        $display("CHECKS FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_addr(input umi_addr_t got, input umi_addr_t exp, input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_cmd(input umi_cmd_t got, input umi_cmd_t exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: cmd got %h expected %h", $time, got, exp);
            abort_run();
        end
    endtask

    task automatic check_data(input umi_data_t got, input umi_data_t exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: data got %h expected %h", $time, got, exp);
            abort_run();
        end
    endtask

    // one register write, model follows the same map
    task automatic cfg_write_reg(input int idx, input umi_addr_t wdata);
        @(posedge clk);
        cfg_write <= 1'b1;
        cfg_addr  <= cfg_addr_t'(idx);
        cfg_wdata <= wdata;
        case (idx)
            0: chipid_m = wdata[15:0];
            1: low_m    = wdata;
            2: high_m   = wdata;
            3: offset_m = wdata;
            default: begin
                if (idx >= 16 && idx < 16 + NMAPS) begin
                    old_m[idx-16]   = wdata[15:0];
                    new_m[idx-16]   = wdata[31:16];
                    valid_m[idx-16] = wdata[32];
                end
            end
        endcase
        @(posedge clk);
        cfg_write <= 1'b0;
    endtask

    task automatic map_entry(input int idx, input umi_chipid_t old_id,
                             input umi_chipid_t new_id, input logic vld);
        cfg_write_reg(16 + idx, {31'b0, vld, new_id, old_id});
    endtask

    // one beat upstream, waits for a credit first
    task automatic send_req(input umi_addr_t dst);
        umi_cmd_t  cmd;
        umi_addr_t src;
        umi_data_t data;
        cmd  = stim_rand();
        src  = {stim_rand(), stim_rand()};
        data = {stim_rand(), stim_rand()};
        @(posedge clk);
        while (sent_cnt - up_returned >= DEPTH) begin
            in_valid <= 1'b0;   // out of credit, stall
            @(posedge clk);
        end
        traffic_started = 1'b1;
        in_valid   <= 1'b1;
        in_cmd     <= cmd;
        in_dstaddr <= dst;
        in_srcaddr <= src;
        in_data    <= data;
        sent_cnt++;
        exp_cmd_q.push_back(cmd);
        exp_dst_q.push_back(remap_addr(dst));
        exp_src_q.push_back(src);
        exp_data_q.push_back(data);
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    // all beats out and all upstream credits back
    task automatic wait_drain();
        idle_cycle();
        while (exp_dst_q.size() != 0 || up_returned != sent_cnt)
            @(posedge clk);
        repeat (2) @(posedge clk);
    endtask

    task automatic send_random(input int n);
        int k;
        for (k = 0; k < n; k++) begin
            if (stim_rand() % 4 == 0)
                idle_cycle();   // gap in the request stream
            send_req(rand_addr());
        end
    endtask

    // receiver: one credit back per beat, after a random delay
    always @(posedge clk) begin
        if (out_credit === 1'b1)
            down_returned <= down_returned + 1;
        if (out_valid === 1'b1) begin
            down_rng = lcg_next(down_rng);
            due_q.push_back(cyc + 1 + int'(down_rng[30:16] % down_max_delay));
        end
        if (due_q.size() != 0 && due_q[0] <= cyc) begin
            out_credit <= 1'b1;
            void'(due_q.pop_front());
        end else
            out_credit <= 1'b0;
    end

    // scoreboard, in order
    always @(posedge clk) begin
        if (arst_n === 1'b1 && out_valid === 1'b1) begin
            if (exp_dst_q.size() == 0) begin
                $display("ERROR at %0t: output beat with no request outstanding", $time);
                abort_run();
            end else if (beats_seen >= OUT_CREDITS + down_returned) begin
                $display("ERROR at %0t: output beat sent without downstream credit", $time);
                abort_run();
            end else begin
                check_cmd(out_cmd, exp_cmd_q.pop_front());
                check_addr(out_dstaddr, exp_dst_q.pop_front(), "dstaddr");
                check_addr(out_srcaddr, exp_src_q.pop_front(), "srcaddr");
                check_data(out_data, exp_data_q.pop_front());
                beats_seen <= beats_seen + 1;
            end
        end
    end

    // upstream credits and quiet outputs before traffic
    always @(posedge clk) begin
        if (in_credit === 1'b1) begin
            up_returned <= up_returned + 1;
            if (up_returned >= sent_cnt) begin
                $display("ERROR at %0t: more upstream credits returned than sent", $time);
                abort_run();
            end
        end
        // first edge still shows the values from before the reset edge
        if (cyc != 0 && !traffic_started && (out_valid !== 1'b0 || in_credit !== 1'b0)) begin
            $display("ERROR at %0t: output active before any request was sent", $time);
            abort_run();
        end
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= CYCLE_LIMIT) begin
            $display("ERROR: run did not finish within %0d cycles", CYCLE_LIMIT);
            abort_run();
        end
    end

    initial begin
        arst_n     = 1'b0;
        in_valid   = 1'b0;
        in_cmd     = '0;
        in_dstaddr = '0;
        in_srcaddr = '0;
        in_data    = '0;
        out_credit = 1'b0;
        cfg_write  = 1'b0;
        cfg_addr   = '0;
        cfg_wdata  = '0;
        chipid_m   = '0;        // model matches the reset values
        low_m      = '1;
        high_m     = '0;
        offset_m   = '0;
        for (int i = 0; i < NMAPS; i++) begin
            old_m[i]   = '0;
            new_m[i]   = '0;
            valid_m[i] = 1'b0;
        end
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;
        repeat (3) @(posedge clk);

        // phase 1, small window, table with duplicates and holes
        cfg_write_reg(0, 64'h00A5);
        cfg_write_reg(1, make_addr(8'h00, 16'h0100, 40'h00_0000_1000));
        cfg_write_reg(2, make_addr(8'h00, 16'h0100, 40'h00_0000_1FFF));
        cfg_write_reg(3, make_addr(8'h00, 16'h0001, 40'h0));
        map_entry(0, 16'h0200, 16'h0300, 1'b1);
        map_entry(1, 16'h0201, 16'h0301, 1'b1);
        map_entry(2, 16'h0200, 16'h0400, 1'b1);  // loses to entry 0
        map_entry(3, 16'h0205, 16'h0305, 1'b0);  // never matches
        map_entry(4, 16'h00A5, 16'h0312, 1'b1);  // local id wins over it
        map_entry(5, 16'h0207, 16'h0307, 1'b0);
        map_entry(6, 16'h0207, 16'h0407, 1'b1);  // hit past an invalid twin
        map_entry(7, 16'h0100, 16'h0313, 1'b1);  // window id outside the window

        send_req(make_addr(8'h3C, 16'h00A5, 40'h12_3456_789A));
        send_req(low_m);
        send_req(high_m);
        send_req(low_m - 1);
        send_req(high_m + 1);
        send_req(make_addr(8'h01, 16'h0200, 40'hAB_CDEF_0123));
        send_req(make_addr(8'h02, 16'h0201, 40'h00_0000_0042));
        send_req(make_addr(8'h03, 16'h0205, 40'hFF_FFFF_FFFF));
        send_req(make_addr(8'h04, 16'h0207, 40'h55_AA55_AA55));
        send_req(make_addr(8'h05, 16'h0999, 40'h01_0203_0405));
        send_req(make_addr(8'hFF, 16'h00A5, 40'h00_0000_1800));
        send_random(N_RAND);
        wait_drain();

        // phase 2, window covers the local id, entry 0 dropped
        cfg_write_reg(1, make_addr(8'h00, 16'h00A0, 40'h0));
        cfg_write_reg(2, make_addr(8'h00, 16'h00AF, 40'hFF_FFFF_FFFF));
        cfg_write_reg(3, make_addr(8'h00, 16'h0010, 40'h0));
        map_entry(0, 16'h0200, 16'h0300, 1'b0);
        down_max_delay <= 12;   // slow receiver from here on

        send_req(make_addr(8'h00, 16'h00A5, 40'h77_0000_0001));
        send_req(make_addr(8'h00, 16'h00A3, 40'h12_0000_0000));
        send_req(low_m);
        send_req(high_m);
        send_req(low_m - 1);
        send_req(high_m + 1);
        send_req(make_addr(8'h09, 16'h0200, 40'h00_1111_2222));
        send_random(N_RAND);
        wait_drain();

        if (beats_seen == sent_cnt && up_returned == sent_cnt) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            $display("ERROR: %0d requests sent, %0d beats out, %0d credits back",
                     sent_cnt, beats_seen, up_returned);
            abort_run();
        end
    end

endmodule

//--- compile.f
+incdir+source
source/umi_remap_pkg.sv
source/umi_credit_fifo.sv
source/umi_addr_remap.sv
source/umi_remap_cfg.sv
source/umi_remap_ctrl.sv
source/umi_remap_top.sv
verif/umi_remap_props.sv
verif/umi_remap_tb.sv
